// File: include/pat_defines.svh
`ifndef PAT_DEFINES_SVH
`define PAT_DEFINES_SVH

// ==================================================
// widths
// ==================================================
`define PAT_DATA_W      8       // accumulator and data word
`define PAT_INSTR_W     20      // full instruction word
`define PAT_IADDR_W     10      // program counter
`define PAT_DADDR_W     5       // data memory index
`define PAT_DMEM_DEPTH  32      // data memory words
`define PAT_SHAMT_W     3       // shift amount, i3 immediate

// escape code, i8 -> i3 and i3 -> i0
`define PAT_PREFIX      4'b1111

// ==================================================
// i8 opcodes, bits 11..8
// ==================================================
`define PAT_OP_OR       4'b0000
`define PAT_OP_AND      4'b0001
`define PAT_OP_ADDM     4'b0010
`define PAT_OP_SUBM     4'b0011
`define PAT_OP_ADD      4'b0100
`define PAT_OP_SUB      4'b0101
`define PAT_OP_LDI      4'b0110
`define PAT_OP_LDM      4'b0111
`define PAT_OP_BF       4'b1000 // signed forward branch
`define PAT_OP_BB       4'b1001 // unsigned backward branch
`define PAT_OP_STAM     4'b1011
`define PAT_OP_ORM      4'b1101
`define PAT_OP_ANDM     4'b1110

// i3 opcodes, bits 7..4
`define PAT_OP3_SHL     4'b0000
`define PAT_OP3_SHLO    4'b0001 // left shift, ones in
`define PAT_OP3_SHR     4'b0010
`define PAT_OP3_ASR     4'b0011
`define PAT_OP3_IN      4'b0101
`define PAT_OP3_OUT     4'b1000

// i0 opcodes, bits 3..0
`define PAT_OP0_NOT     4'b0000
`define PAT_OP0_NOP     4'b1111

`endif

// File: source/pat_pkg.sv
`include "pat_defines.svh"

package pat_pkg;

	// ==================================================
	// plain vectors
	// ==================================================
	typedef logic [`PAT_DATA_W-1:0]  pat_word_t;   // data / acc word
	typedef logic [`PAT_INSTR_W-1:0] pat_instr_t;  // raw instruction
	typedef logic [`PAT_IADDR_W-1:0] pat_iaddr_t;  // pc value
	typedef logic [`PAT_DADDR_W-1:0] pat_daddr_t;  // dmem index

	// alu operation select
	typedef enum logic [3:0]
	{
		ALU_OR,
		ALU_AND,
		ALU_NOT,
		ALU_ADD,
		ALU_SUB,
		ALU_SHL,
		ALU_SHLO,
		ALU_SHR,
		ALU_ASR,
		ALU_PASS_B     // ldi, ldm
	} pat_alu_op_e;

	// commit condition, straight from bits 14..13
	typedef enum logic [1:0]
	{
		COND_ZERO    = 2'd0,
		COND_NEG     = 2'd1,
		COND_ALWAYS2 = 2'd2,   // spare code, commits too
		COND_ALWAYS  = 2'd3
	} pat_cond_e;

	// acc write source
	typedef enum logic [1:0]
	{
		SRC_ALU,
		SRC_IN
	} pat_src_e;

	// ==================================================
	// stage 1 -> stage 2 control word
	// ==================================================
	typedef struct packed
	{
		pat_alu_op_e alu_op;
		pat_src_e    src;
		pat_cond_e   cond;
		pat_word_t   operand;   // alu b, imm or mem word
		logic        wr_acc;
		logic        wr_mem;    // stam
		logic        do_out;    // out
		pat_daddr_t  mem_idx;
	} pat_ctrl_t;

	// data memory write port
	typedef struct packed
	{
		logic       en;
		pat_daddr_t idx;
		pat_word_t  data;
	} pat_dmem_wr_t;

endpackage

// File: source/pat_alu.sv
`timescale 1ns/100ps
`include "pat_defines.svh"

module pat_alu
(
	input  pat_pkg::pat_word_t   i_a,     // accumulator
	input  pat_pkg::pat_word_t   i_b,     // operand
	input  pat_pkg::pat_alu_op_e i_op,
	output pat_pkg::pat_word_t   o_y
);

	logic                    is_sub;
	pat_pkg::pat_word_t      b_addend;
	pat_pkg::pat_word_t      sum;
	pat_pkg::pat_word_t      shlo;
	logic [`PAT_SHAMT_W-1:0] shamt;

	// ==================================================
	// shared add / subtract
	// ==================================================
	assign is_sub   = (i_op == pat_pkg::ALU_SUB);
	assign b_addend = is_sub ? ~i_b : i_b;                 // invert b for sub
	assign sum      = i_a + b_addend + {{(`PAT_DATA_W-1){1'b0}}, is_sub};   // +1 carry in

	// shifter
	assign shamt = i_b[`PAT_SHAMT_W-1:0];
	assign shlo  = ~(~i_a << shamt);     // vacated bits come in as ones

	always_comb
	begin
		case (i_op)
			pat_pkg::ALU_OR:   o_y = i_a | i_b;
			pat_pkg::ALU_AND:  o_y = i_a & i_b;
			pat_pkg::ALU_NOT:  o_y = ~i_a;
			pat_pkg::ALU_ADD,
			pat_pkg::ALU_SUB:  o_y = sum;
			pat_pkg::ALU_SHL:  o_y = i_a << shamt;
			pat_pkg::ALU_SHLO: o_y = shlo;
			pat_pkg::ALU_SHR:  o_y = i_a >> shamt;
			pat_pkg::ALU_ASR:  o_y = pat_pkg::pat_word_t'($signed(i_a) >>> shamt);
			default:           o_y = i_b;        // pass b, ldi / ldm
		endcase
	end

endmodule

// File: source/pat_decode.sv
`timescale 1ns/100ps
`include "pat_defines.svh"

module pat_decode
(
	input  logic                 clk,
	input  logic                 reset,
	input  pat_pkg::pat_instr_t  i_instr,
	input  pat_pkg::pat_word_t   i_rd_data,     // dmem word, combinational
	output pat_pkg::pat_daddr_t  o_rd_idx,
	output logic                 o_branch_fwd,
	output logic                 o_branch_back,
	output pat_pkg::pat_word_t   o_offset,
	output pat_pkg::pat_ctrl_t   o_ctrl
);

	// idle control word, nothing commits
	localparam pat_pkg::pat_ctrl_t CTRL_NOP = '{
		alu_op:  pat_pkg::ALU_PASS_B,
		src:     pat_pkg::SRC_ALU,
		cond:    pat_pkg::COND_ALWAYS,
		operand: '0,
		wr_acc:  1'b0,
		wr_mem:  1'b0,
		do_out:  1'b0,
		mem_idx: '0
	};

	pat_pkg::pat_instr_t instr_q;        // stage 1 instruction
	pat_pkg::pat_ctrl_t  ctrl_d;

	logic [1:0]                cond;
	logic [3:0]                op8;
	logic [3:0]                op3;
	logic [3:0]                op0;
	pat_pkg::pat_word_t        imm8;
	logic [`PAT_SHAMT_W-1:0]   imm3;
	logic                      is_i8;
	logic                      is_i3;

	// ==================================================
	// instruction register
	// ==================================================
	always_ff @(posedge clk)
	begin
		if (reset)
			instr_q <= '1;      // all ones decodes as i0 nop
		else
			instr_q <= i_instr;
	end

	// field split, bits 19..15 and 12 unused
	assign cond = instr_q[14:13];
	assign op8  = instr_q[11:8];
	assign imm8 = instr_q[7:0];
	assign op3  = instr_q[7:4];
	assign op0  = instr_q[3:0];
	assign imm3 = instr_q[`PAT_SHAMT_W-1:0];

	assign is_i8 = (op8 != `PAT_PREFIX);
	assign is_i3 = !is_i8 && (op3 != `PAT_PREFIX);   // else i0

	assign o_rd_idx = imm8[`PAT_DADDR_W-1:0];        // low bits index dmem
	assign o_offset = imm8;

	// ==================================================
	// operation decode
	// ==================================================
	always_comb
	begin
		ctrl_d        = CTRL_NOP;
		ctrl_d.cond   = pat_pkg::pat_cond_e'(cond);
		ctrl_d.mem_idx = imm8[`PAT_DADDR_W-1:0];
		o_branch_fwd  = 1'b0;
		o_branch_back = 1'b0;
		if (is_i8)
		begin
			case (op8)
				`PAT_OP_OR:   begin ctrl_d.alu_op = pat_pkg::ALU_OR;  ctrl_d.operand = imm8; ctrl_d.wr_acc = 1'b1; end
				`PAT_OP_AND:  begin ctrl_d.alu_op = pat_pkg::ALU_AND; ctrl_d.operand = imm8; ctrl_d.wr_acc = 1'b1; end
				`PAT_OP_ADD:  begin ctrl_d.alu_op = pat_pkg::ALU_ADD; ctrl_d.operand = imm8; ctrl_d.wr_acc = 1'b1; end
				`PAT_OP_SUB:  begin ctrl_d.alu_op = pat_pkg::ALU_SUB; ctrl_d.operand = imm8; ctrl_d.wr_acc = 1'b1; end
				`PAT_OP_ADDM: begin ctrl_d.alu_op = pat_pkg::ALU_ADD; ctrl_d.operand = i_rd_data; ctrl_d.wr_acc = 1'b1; end
				`PAT_OP_SUBM: begin ctrl_d.alu_op = pat_pkg::ALU_SUB; ctrl_d.operand = i_rd_data; ctrl_d.wr_acc = 1'b1; end
				`PAT_OP_ORM:  begin ctrl_d.alu_op = pat_pkg::ALU_OR;  ctrl_d.operand = i_rd_data; ctrl_d.wr_acc = 1'b1; end
				`PAT_OP_ANDM: begin ctrl_d.alu_op = pat_pkg::ALU_AND; ctrl_d.operand = i_rd_data; ctrl_d.wr_acc = 1'b1; end
				`PAT_OP_LDI:  begin ctrl_d.operand = imm8;      ctrl_d.wr_acc = 1'b1; end   // pass b
				`PAT_OP_LDM:  begin ctrl_d.operand = i_rd_data; ctrl_d.wr_acc = 1'b1; end
				`PAT_OP_STAM: ctrl_d.wr_mem = 1'b1;
				`PAT_OP_BF:   o_branch_fwd  = 1'b1;    // condition ignored
				`PAT_OP_BB:   o_branch_back = 1'b1;
				default:      ;                        // unused code, nop
			endcase
		end
		else if (is_i3)
		begin
			// shifts use the 3 bit imm as amount
			ctrl_d.operand = {{(`PAT_DATA_W-`PAT_SHAMT_W){1'b0}}, imm3};
			case (op3)
				`PAT_OP3_SHL:  begin ctrl_d.alu_op = pat_pkg::ALU_SHL;  ctrl_d.wr_acc = 1'b1; end
				`PAT_OP3_SHLO: begin ctrl_d.alu_op = pat_pkg::ALU_SHLO; ctrl_d.wr_acc = 1'b1; end
				`PAT_OP3_SHR:  begin ctrl_d.alu_op = pat_pkg::ALU_SHR;  ctrl_d.wr_acc = 1'b1; end
				`PAT_OP3_ASR:  begin ctrl_d.alu_op = pat_pkg::ALU_ASR;  ctrl_d.wr_acc = 1'b1; end
				`PAT_OP3_IN:   begin ctrl_d.src = pat_pkg::SRC_IN; ctrl_d.wr_acc = 1'b1; end
				`PAT_OP3_OUT:  ctrl_d.do_out = 1'b1;
				default:       ;
			endcase
		end
		else
		begin
			case (op0)
				`PAT_OP0_NOT: begin ctrl_d.alu_op = pat_pkg::ALU_NOT; ctrl_d.wr_acc = 1'b1; end
				`PAT_OP0_NOP: ;        // explicit nop
				default:      ;
			endcase
		end
	end

	// control word to stage 2
	always_ff @(posedge clk)
	begin
		if (reset)
			o_ctrl <= CTRL_NOP;
		else
			o_ctrl <= ctrl_d;
	end

endmodule

// File: source/pat_program_counter.sv
`timescale 1ns/100ps
`include "pat_defines.svh"

module pat_program_counter
(
	input  logic                clk,
	input  logic                reset,
	input  logic                i_branch_fwd,
	input  logic                i_branch_back,
	input  pat_pkg::pat_word_t  i_offset,
	output pat_pkg::pat_iaddr_t o_pc
);

	pat_pkg::pat_iaddr_t pc_inc;
	pat_pkg::pat_iaddr_t pc_fwd;
	pat_pkg::pat_iaddr_t pc_back;

	assign pc_inc = o_pc + 1'b1;

	// bf offset is signed, sign extend to pc width
	assign pc_fwd = o_pc + {{(`PAT_IADDR_W-`PAT_DATA_W){i_offset[`PAT_DATA_W-1]}}, i_offset};

	// bb offset is unsigned
	assign pc_back = o_pc - {{(`PAT_IADDR_W-`PAT_DATA_W){1'b0}}, i_offset};

	always_ff @(posedge clk)
	begin
		if (reset)
			o_pc <= '0;
		else if (i_branch_fwd)
			o_pc <= pc_fwd;
		else if (i_branch_back)
			o_pc <= pc_back;
		else
			o_pc <= pc_inc;    // straight line
	end

endmodule

// File: source/pat_data_mem.sv
`timescale 1ns/100ps
`include "pat_defines.svh"

module pat_data_mem
(
	input  logic                  clk,
	input  pat_pkg::pat_daddr_t   i_rd_idx,
	output pat_pkg::pat_word_t    o_rd_data,
	input  pat_pkg::pat_dmem_wr_t i_wr
);

	pat_pkg::pat_word_t mem [`PAT_DMEM_DEPTH];

	// async read, decode samples it into the ctrl word
	assign o_rd_data = mem[i_rd_idx];

	// write lands on the commit edge
	always_ff @(posedge clk)
	begin
		if (i_wr.en)
			mem[i_wr.idx] <= i_wr.data;
	end

endmodule

// File: source/pat_execute.sv
`timescale 1ns/100ps
`include "pat_defines.svh"

module pat_execute
(
	input  logic                  clk,
	input  logic                  reset,
	input  pat_pkg::pat_ctrl_t    i_ctrl,
	input  pat_pkg::pat_word_t    i_inputs,
	output pat_pkg::pat_dmem_wr_t o_wr,
	output pat_pkg::pat_word_t    o_outputs
);

	pat_pkg::pat_word_t acc;        // the accumulator
	pat_pkg::pat_word_t alu_y;
	pat_pkg::pat_word_t result;
	logic               z;          // zero flag, one cycle behind acc
	logic               n;          // neg flag, same lag
	logic               cond_ok;

	pat_alu u_alu
	(
		.i_a  (acc),
		.i_b  (i_ctrl.operand),
		.i_op (i_ctrl.alu_op),
		.o_y  (alu_y)
	);

	// ==================================================
	// condition check
	// ==================================================
	always_comb
	begin
		case (i_ctrl.cond)
			pat_pkg::COND_ZERO: cond_ok = z;
			pat_pkg::COND_NEG:  cond_ok = n;
			default:            cond_ok = 1'b1;    // both always codes
		endcase
	end

	assign result = (i_ctrl.src == pat_pkg::SRC_IN) ? i_inputs : alu_y;

	// stam strobe straight off the ctrl and flag flops
	// so the word is in memory at the commit edge
	assign o_wr = '{
		en:   i_ctrl.wr_mem & cond_ok,
		idx:  i_ctrl.mem_idx,
		data: acc
	};

	// ==================================================
	// commit
	// ==================================================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			acc       <= '0;
			z         <= 1'b0;
			n         <= 1'b0;
			o_outputs <= '0;
		end
		else
		begin
			z <= (acc == '0);               // flags track acc every cycle
			n <= acc[`PAT_DATA_W-1];
			if (cond_ok && i_ctrl.wr_acc)
				acc <= result;
			if (cond_ok && i_ctrl.do_out)
				o_outputs <= acc;           // value before this commit
		end
	end

endmodule

// File: source/pat_core.sv
`timescale 1ns/100ps
`include "pat_defines.svh"

module pat_core
(
	input  logic                clk,
	input  logic                reset,
	input  pat_pkg::pat_instr_t i_instr,     // fed by tb at o_pc
	input  pat_pkg::pat_word_t  i_inputs,
	output pat_pkg::pat_iaddr_t o_pc,
	output pat_pkg::pat_word_t  o_outputs
);

	pat_pkg::pat_ctrl_t    ctrl;
	pat_pkg::pat_dmem_wr_t dmem_wr;
	pat_pkg::pat_daddr_t   rd_idx;
	pat_pkg::pat_word_t    rd_data;
	pat_pkg::pat_word_t    offset;
	logic                  branch_fwd;
	logic                  branch_back;

	// ==================================================
	// stage 1, decode and pc
	// ==================================================
	pat_decode u_decode
	(
		.clk           (clk),
		.reset         (reset),
		.i_instr       (i_instr),
		.i_rd_data     (rd_data),
		.o_rd_idx      (rd_idx),
		.o_branch_fwd  (branch_fwd),
		.o_branch_back (branch_back),
		.o_offset      (offset),
		.o_ctrl        (ctrl)
	);

	pat_program_counter u_pc
	(
		.clk           (clk),
		.reset         (reset),
		.i_branch_fwd  (branch_fwd),
		.i_branch_back (branch_back),
		.i_offset      (offset),
		.o_pc          (o_pc)
	);

	pat_data_mem u_dmem
	(
		.clk       (clk),
		.i_rd_idx  (rd_idx),
		.o_rd_data (rd_data),
		.i_wr      (dmem_wr)
	);

	// stage 2, alu and commit
	pat_execute u_execute
	(
		.clk       (clk),
		.reset     (reset),
		.i_ctrl    (ctrl),
		.i_inputs  (i_inputs),
		.o_wr      (dmem_wr),
		.o_outputs (o_outputs)
	);

endmodule

// File: testbench/pat_properties.sv
`timescale 1ns/100ps
`include "pat_defines.svh"

module pat_properties
(
	input logic                clk,
	input logic                reset,
	input logic                wr_en,        // dmem write strobe
	input logic                branch_fwd,
	input logic                branch_back,
	input logic                do_out,       // out in the ctrl word
	input pat_pkg::pat_iaddr_t o_pc,
	input pat_pkg::pat_word_t  o_outputs
);

	int fails = 0;      // failed assertion count

	// ==================================================
	// core checks
	// ==================================================
	a_known : assert property (@(posedge clk) disable iff (reset)
		!$isunknown({wr_en, o_pc}))
	else
	begin
		fails++;
		$error("write strobe or pc unknown");
	end

	// straight line code steps by one, not from the release edge
	a_pc_inc : assert property (@(posedge clk) disable iff (reset)
		(!reset && !branch_fwd && !branch_back)
		|=> (o_pc == pat_pkg::pat_iaddr_t'($past(o_pc) + 1'b1)))
	else
	begin
		fails++;
		$error("pc did not advance by one");
	end

	a_out_only : assert property (@(posedge clk) disable iff (reset)
		(o_outputs != $past(o_outputs)) |-> $past(do_out))
	else
	begin
		fails++;
		$error("o_outputs changed without an out");
	end

endmodule

bind pat_core pat_properties u_props
(
	.clk         (clk),
	.reset       (reset),
	.wr_en       (dmem_wr.en),
	.branch_fwd  (branch_fwd),
	.branch_back (branch_back),
	.do_out      (ctrl.do_out),
	.o_pc        (o_pc),
	.o_outputs   (o_outputs)
);

// File: testbench/pat_tb.sv
`timescale 1ns/100ps
`include "pat_defines.svh"

module pat_tb;

	// one program word plus what to expect from it
	typedef struct packed
	{
		pat_pkg::pat_instr_t instr;
		logic                chk_out;    // out row, compare o_outputs
		pat_pkg::pat_word_t  exp_out;
		logic                chk_pc;     // branch row, compare o_pc
		pat_pkg::pat_iaddr_t exp_pc;
	} row_t;

	localparam int PROG_DEPTH  = 64;
	localparam int LAST_ADDR   = 56;     // final row of the program
	localparam int RUN_LIMIT   = 300;    // cycles before giving up
	localparam int RESET_LIMIT = 20;
	localparam pat_pkg::pat_instr_t NOP_WORD = '1;   // i0 nop, always cond
	localparam logic [1:0] CA = 2'd3;    // always
	localparam logic [1:0] CZ = 2'd0;    // zero flag

	logic                clk;
	logic                reset;
	pat_pkg::pat_instr_t i_instr;
	pat_pkg::pat_word_t  i_inputs;
	pat_pkg::pat_iaddr_t o_pc;
	pat_pkg::pat_word_t  o_outputs;

	row_t prog [PROG_DEPTH];
	int   hist [RUN_LIMIT];      // address fed at each cycle
	int   errors;
	int   checks;
	int   timeouts;
	int   pc_model;              // pc after the current edge
	int   cyc;
	int   wait_cnt;
	logic done;
	pat_pkg::pat_instr_t q_instr;
	pat_pkg::pat_word_t  v_shl;
	pat_pkg::pat_word_t  v_shr;
	pat_pkg::pat_word_t  v_asr;
	pat_pkg::pat_word_t  v_shlo;
	pat_pkg::pat_word_t  v_in;
	pat_pkg::pat_word_t  e;

	pat_core u_dut
	(
		.clk       (clk),
		.reset     (reset),
		.i_instr   (i_instr),
		.i_inputs  (i_inputs),
		.o_pc      (o_pc),
		.o_outputs (o_outputs)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;    // 100 ns period

	// ==================================================
	// instruction builders
	// ==================================================
	function automatic pat_pkg::pat_instr_t make_i8(input logic [1:0] cond,
		input logic [3:0] op, input pat_pkg::pat_word_t imm);
		make_i8 = {5'b0, cond, 1'b0, op, imm};
	endfunction

	function automatic pat_pkg::pat_instr_t make_i3(input logic [1:0] cond,
		input logic [3:0] op3, input logic [2:0] amt);
		make_i3 = {5'b0, cond, 1'b0, `PAT_PREFIX, op3, 1'b0, amt};
	endfunction

	function automatic pat_pkg::pat_instr_t make_i0(input logic [1:0] cond,
		input logic [3:0] op0);
		make_i0 = {5'b0, cond, 1'b0, `PAT_PREFIX, `PAT_PREFIX, op0};
	endfunction

	// pc rule: bf signed add, bb unsigned subtract, else plus one
	function automatic int next_pc(input int pc, input pat_pkg::pat_instr_t instr);
		logic [3:0]         op;
		pat_pkg::pat_word_t imm;
		op  = instr[11:8];
		imm = instr[7:0];
		if (op == `PAT_OP_BF)
			return (pc + int'($signed(imm))) & 1023;
		else if (op == `PAT_OP_BB)
			return (pc - int'(imm)) & 1023;
		return (pc + 1) & 1023;
	endfunction

	task automatic set_row(input int a, input pat_pkg::pat_instr_t instr,
		input logic chk, input pat_pkg::pat_word_t exp);
		prog[a] = '{instr: instr, chk_out: chk, exp_out: exp, chk_pc: 1'b0, exp_pc: '0};
	endtask

	task automatic set_branch(input int a, input pat_pkg::pat_instr_t instr,
		input int exp);
		prog[a] = '{instr: instr, chk_out: 1'b0, exp_out: '0, chk_pc: 1'b1,
			exp_pc: pat_pkg::pat_iaddr_t'(exp)};
	endtask

	task automatic check_word(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERROR %0t: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	// ==================================================
	// program table
	// ==================================================
	task automatic build_program;
		pat_pkg::pat_instr_t out_w;
		out_w = make_i3(CA, `PAT_OP3_OUT, 3'd0);
		for (int a = 0; a < PROG_DEPTH; a++)
			set_row(a, NOP_WORD, 1'b0, '0);
		// immediate alu ops
		set_row(0, make_i8(CA, `PAT_OP_LDI, 8'h3c), 1'b0, '0);
		set_row(1, make_i8(CA, `PAT_OP_OR, 8'h81), 1'b0, '0);
		set_row(2, out_w, 1'b1, 8'hbd);
		set_row(3, make_i8(CA, `PAT_OP_AND, 8'h0f), 1'b0, '0);
		set_row(4, out_w, 1'b1, 8'h0d);
		set_row(5, make_i8(CA, `PAT_OP_ADD, 8'hf8), 1'b0, '0);
		set_row(6, out_w, 1'b1, 8'h05);                   // carry dropped
		set_row(7, make_i8(CA, `PAT_OP_SUB, 8'h07), 1'b0, '0);
		set_row(8, out_w, 1'b1, 8'hfe);                   // wraps below zero
		// memory operands
		set_row(9, make_i8(CA, `PAT_OP_LDI, 8'h5a), 1'b0, '0);
		set_row(10, make_i8(CA, `PAT_OP_STAM, 8'd3), 1'b0, '0);
		set_row(11, make_i8(CA, `PAT_OP_LDI, 8'h21), 1'b0, '0);
		set_row(12, make_i8(CA, `PAT_OP_STAM, 8'd17), 1'b0, '0);
		set_row(14, make_i8(CA, `PAT_OP_LDI, 8'h10), 1'b0, '0);
		set_row(15, make_i8(CA, `PAT_OP_ADDM, 8'd3), 1'b0, '0);
		set_row(16, make_i8(CA, `PAT_OP_SUBM, 8'd17), 1'b0, '0);
		set_row(17, out_w, 1'b1, 8'h49);
		set_row(18, make_i8(CA, `PAT_OP_ORM, 8'd17), 1'b0, '0);
		set_row(19, make_i8(CA, `PAT_OP_ANDM, 8'd3), 1'b0, '0);
		set_row(20, out_w, 1'b1, 8'h48);
		set_row(21, make_i8(CA, `PAT_OP_LDM, 8'd17), 1'b0, '0);
		set_row(22, out_w, 1'b1, 8'h21);
		// shifts and not on random words
		set_row(23, make_i8(CA, `PAT_OP_LDI, v_shl), 1'b0, '0);
		set_row(24, make_i3(CA, `PAT_OP3_SHL, 3'd3), 1'b0, '0);
		e = v_shl << 3;
		set_row(25, out_w, 1'b1, e);
		set_row(26, make_i8(CA, `PAT_OP_LDI, v_shr), 1'b0, '0);
		set_row(27, make_i3(CA, `PAT_OP3_SHR, 3'd2), 1'b0, '0);
		e = v_shr >> 2;
		set_row(28, out_w, 1'b1, e);
		set_row(29, make_i8(CA, `PAT_OP_LDI, v_asr), 1'b0, '0);
		set_row(30, make_i3(CA, `PAT_OP3_ASR, 3'd5), 1'b0, '0);
		e = (v_asr >> 5) | 8'hf8;                         // msb set, sign fills
		set_row(31, out_w, 1'b1, e);
		set_row(32, make_i8(CA, `PAT_OP_LDI, v_shlo), 1'b0, '0);
		set_row(33, make_i3(CA, `PAT_OP3_SHLO, 3'd4), 1'b0, '0);
		e = (v_shlo << 4) | 8'h0f;                        // ones shifted in
		set_row(34, out_w, 1'b1, e);
		set_row(35, make_i0(CA, `PAT_OP0_NOT), 1'b0, '0);
		set_row(36, out_w, 1'b1, ~e);
		// input port, conditional commit
		set_row(37, make_i3(CA, `PAT_OP3_IN, 3'd0), 1'b0, '0);
		set_row(38, out_w, 1'b1, v_in);
		set_row(39, make_i8(CA, `PAT_OP_LDI, 8'h00), 1'b0, '0);
		set_row(41, make_i8(CZ, `PAT_OP_LDI, 8'h77), 1'b0, '0);   // z set, commits
		set_row(42, out_w, 1'b1, 8'h77);
		set_row(43, make_i8(CA, `PAT_OP_LDI, 8'h05), 1'b0, '0);
		set_row(45, make_i8(CZ, `PAT_OP_LDI, 8'h99), 1'b0, '0);   // z clear, skipped
		set_row(46, out_w, 1'b1, 8'h05);
		// ==================================================
		// branches, each with one delay slot
		// ==================================================
		set_branch(47, make_i8(CA, `PAT_OP_BF, 8'd4), 52);
		set_row(48, make_i8(CA, `PAT_OP_LDI, 8'h11), 1'b0, '0);   // delay slot runs
		set_branch(52, make_i8(CA, `PAT_OP_BB, 8'd4), 49);
		set_branch(49, make_i8(CA, `PAT_OP_BF, 8'd5), 55);
		set_row(51, make_i8(CA, `PAT_OP_LDI, 8'hee), 1'b0, '0);   // never fetched
		set_row(54, make_i8(CA, `PAT_OP_LDI, 8'hee), 1'b0, '0);
		set_row(55, out_w, 1'b1, 8'h11);
	endtask

	// ==================================================
	// main sequence
	// ==================================================
	initial
	begin
		errors   = 0;
		checks   = 0;
		timeouts = 0;
		done     = 1'b0;
		reset    = 1'b1;
		i_instr  = NOP_WORD;
		i_inputs = '0;
		void'($urandom(32'h209db744));
		v_shl  = $urandom;
		v_shr  = $urandom;
		v_asr  = $urandom | 8'h80;
		v_shlo = $urandom;
		v_in   = $urandom;
		build_program();

		repeat (8) @(posedge clk);
		reset    <= 1'b0;          // first fetch on the release edge
		i_inputs <= v_in;
		i_instr  <= prog[0].instr;
		hist[0]  = 0;
		pc_model = 0;

		wait_cnt = 0;
		@(negedge clk);
		while (reset !== 1'b0 && wait_cnt < RESET_LIMIT)
		begin
			@(negedge clk);
			wait_cnt++;
		end
		if (reset !== 1'b0)
		begin
			timeouts++;
			$display("reset was never released");
		end
		check_word("o_pc after reset", o_pc, 0);
		check_word("o_outputs after reset", o_outputs, 0);

		cyc = 1;
		while (!done && cyc < RUN_LIMIT)
		begin
			@(posedge clk);
			// word in the instruction register decides this edge's pc
			q_instr = (cyc < 2) ? NOP_WORD : prog[hist[cyc-2]].instr;
			pc_model = next_pc(pc_model, q_instr);
			if (pc_model < PROG_DEPTH)
				i_instr <= prog[pc_model].instr;
			else
				i_instr <= NOP_WORD;
			hist[cyc] = pc_model;
			@(negedge clk);
			check_word("o_pc", o_pc, pc_model);
			if (cyc >= 2 && prog[hist[cyc-2]].chk_pc)
				check_word("branch target", o_pc, prog[hist[cyc-2]].exp_pc);
			if (cyc >= 3)
			begin
				if (prog[hist[cyc-3]].chk_out)
					check_word("o_outputs", o_outputs, prog[hist[cyc-3]].exp_out);
				if (hist[cyc-3] == LAST_ADDR)
					done = 1'b1;
			end
			cyc++;
		end
		if (!done)
		begin
			timeouts++;
			$display("program did not reach its last row in time");
		end

		$display("checks %0d, errors %0d, timeouts %0d, assertion fails %0d",
			checks, errors, timeouts, u_dut.u_props.fails);
		if (errors == 0 && timeouts == 0 && u_dut.u_props.fails == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// File: tb.f
+incdir+include
source/pat_pkg.sv
source/pat_alu.sv
source/pat_decode.sv
source/pat_program_counter.sv
source/pat_data_mem.sv
source/pat_execute.sv
source/pat_core.sv
testbench/pat_properties.sv
testbench/pat_tb.sv

// File: Bender.yml
package:
  name: pat_core

export_include_dirs:
  - include

sources:
  - files:
      - source/pat_pkg.sv
      - source/pat_alu.sv
      - source/pat_decode.sv
      - source/pat_program_counter.sv
      - source/pat_data_mem.sv
      - source/pat_execute.sv
      - source/pat_core.sv
  - target: test
    files:
      - testbench/pat_properties.sv
      - testbench/pat_tb.sv
